/* hpll_calib_pkg.sv */
////////////////////////////////////////
// shared definitions for the calibration
// sequencer: state enum, config bus widths,
// register addresses, counter marks, fields
////////////////////////////////////////
`default_nettype none

package hpll_calib_pkg;

    typedef enum logic [2:0] {
        idle         = 3'd0,
        detect       = 3'd1,
        calib_start  = 3'd2,
        calib_wait   = 3'd3,
        calib_exit   = 3'd4,
        valid_done   = 3'd5,
        invalid_done = 3'd6,
        abort_done   = 3'd7
    } calib_state_e;

    // config bus
    localparam int ADDR_W = 12;
    localparam int DATA_W = 8;

    localparam logic [ADDR_W-1:0] ADDR_REFCLK_CFG    = 12'h003;
    localparam logic [ADDR_W-1:0] ADDR_CALIB_STATUS  = 12'h026;
    localparam logic [ADDR_W-1:0] ADDR_RESCAL_RESULT = 12'h03c;

    // counter marks
    localparam logic [3:0] DET_READ1_END = 4'd4;   // first read sampled here
    localparam logic [3:0] DET_GAP       = 4'd5;   // idle slot between reads
    localparam logic [3:0] DET_END       = 4'd10;
    localparam logic [3:0] INIT_END      = 4'd15;  // settling done
    localparam logic [1:0] WR_LAST       = 2'd3;
    localparam logic [2:0] POLL_LAST     = 3'd5;

    // register fields
    localparam int STATUS_BLOCK_LO = 4;
    localparam int STATUS_BLOCK_HI = 5;
    localparam int RESCAL_DONE_BIT = 0;
    localparam int CFG_FORCE_LO    = 3;
    localparam int CFG_FORCE_HI    = 5;

endpackage

`default_nettype wire

/* calib_fsm.sv */
////////////////////////////////////////
// calibration sequencer FSM
// ready error count, done flag and the
// rescal reset pulse
////////////////////////////////////////
`default_nettype none

module calib_fsm #(
    parameter int MAX_RDY_ERR = 2
) (
    input  wire                                   clk,
    input  wire                                   rstn,
    input  wire                                   calib_en,
    input  wire  [3:0]                            det_cnt,
    input  wire  [1:0]                            wr_cnt,
    input  wire  [2:0]                            poll_cnt,
    input  wire                                   cfg_ready,
    input  wire  [hpll_calib_pkg::DATA_W-1:0]     cfg_rdata,
    output hpll_calib_pkg::calib_state_e          state,
    output logic                                  calib_done,
    output logic                                  res_cal_rst
);
    import hpll_calib_pkg::*;

    localparam int ERR_W = $clog2(MAX_RDY_ERR + 1);

    calib_state_e     state_nxt;
    logic [ERR_W-1:0] err_cnt;
    logic             rdy_err;
    logic             calib_vld;
    logic             start_rdy;
    logic             res_done;
    logic             exit_rdy;

    ////////////////////////////////////////
    // sample points
    ////////////////////////////////////////
    assign calib_vld = cfg_ready && (cfg_rdata[STATUS_BLOCK_HI:STATUS_BLOCK_LO] == '0);
    assign start_rdy = (state == calib_start) && (wr_cnt == WR_LAST) && cfg_ready;
    assign exit_rdy  = (state == calib_exit) && (wr_cnt == WR_LAST) && cfg_ready;
    assign res_done  = (poll_cnt == POLL_LAST) && cfg_ready && cfg_rdata[RESCAL_DONE_BIT];

    // no late ready is waited for
    always_comb begin
        case (state)
            detect:                 rdy_err = !cfg_ready &&
                                              (det_cnt == DET_READ1_END || det_cnt == DET_END);
            calib_start, calib_exit: rdy_err = !cfg_ready && (wr_cnt == WR_LAST);
            calib_wait:             rdy_err = !cfg_ready && (poll_cnt == POLL_LAST);
            default:                rdy_err = 1'b0;
        endcase
    end

    ////////////////////////////////////////
    // state machine
    ////////////////////////////////////////
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn)
            state <= idle;
        else
            state <= state_nxt;
    end

    always_comb begin
        state_nxt = state;
        case (state)
            idle: begin
                if (det_cnt == INIT_END)
                    state_nxt = detect;
            end
            detect: begin
                if (err_cnt == ERR_W'(MAX_RDY_ERR))
                    state_nxt = abort_done;
                else if (det_cnt == DET_END)
                    state_nxt = calib_vld ? calib_start : invalid_done;
            end
            calib_start: begin
                if (rdy_err)
                    state_nxt = detect;   // retry from detection
                else if (start_rdy)
                    state_nxt = calib_wait;
            end
            calib_wait: begin
                if (rdy_err)
                    state_nxt = detect;
                else if (res_done)
                    state_nxt = calib_exit;
            end
            calib_exit: begin
                if (rdy_err)
                    state_nxt = detect;
                else if (exit_rdy)
                    state_nxt = valid_done;
            end
            default: state_nxt = state;   // done states hold
        endcase
    end

    // ready misses since last idle
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn)
            err_cnt <= '0;
        else if (state == idle)
            err_cnt <= '0;
        else if (rdy_err)
            err_cnt <= err_cnt + 1'b1;
    end

    ////////////////////////////////////////
    // outputs
    ////////////////////////////////////////
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn)
            calib_done <= 1'b0;
        else if (state == valid_done || state == abort_done)
            calib_done <= 1'b1;
        else if (state == invalid_done)
            calib_done <= calib_en;   // user decides when nothing ran
    end

    // one cycle pulse after the start write
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn)
            res_cal_rst <= 1'b0;
        else
            res_cal_rst <= start_rdy;
    end

endmodule

`default_nettype wire

/* calib_step_counters.sv */
////////////////////////////////////////
// phase counters for the sequencer
// detect, write, two-stage wait timer
// and poll counter
////////////////////////////////////////
`default_nettype none

module calib_step_counters #(
    parameter int WAIT_BITS = 10
) (
    input  wire                          clk,
    input  wire                          rstn,
    input  wire hpll_calib_pkg::calib_state_e state,
    output logic [3:0]                   det_cnt,
    output logic [1:0]                   wr_cnt,
    output logic [2:0]                   poll_cnt
);
    import hpll_calib_pkg::*;

    logic [WAIT_BITS-1:0] wait_lo;
    logic [WAIT_BITS-1:0] wait_hi;
    logic                 lo_carry;
    logic                 hi_carry;

    assign lo_carry = wait_lo[WAIT_BITS-1];
    assign hi_carry = wait_hi[WAIT_BITS-1];

    ////////////////////////////////////////
    // detect / settling counter
    ////////////////////////////////////////
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn)
            det_cnt <= '0;
        else if (state == idle)
            det_cnt <= det_cnt + 4'd1;   // settling time
        else if (state == detect)
            det_cnt <= (det_cnt == DET_END) ? 4'd0 : det_cnt + 4'd1;
        else
            det_cnt <= '0;
    end

    // write cycle pacing
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn)
            wr_cnt <= '0;
        else if (state == calib_start || state == calib_exit)
            wr_cnt <= wr_cnt + 2'd1;
        else
            wr_cnt <= '0;
    end

    ////////////////////////////////////////
    // wait timers and poll counter
    ////////////////////////////////////////
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn)
            wait_lo <= '0;
        else if (state == calib_wait && !lo_carry)
            wait_lo <= wait_lo + 1'b1;
        else
            wait_lo <= '0;
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn)
            wait_hi <= '0;
        else if (state != calib_wait || hi_carry)
            wait_hi <= '0;
        else if (lo_carry)
            wait_hi <= wait_hi + 1'b1;
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn)
            poll_cnt <= '0;
        else if (state != calib_wait)
            poll_cnt <= '0;
        else if (poll_cnt == POLL_LAST)
            poll_cnt <= '0;
        else if (hi_carry)
            poll_cnt <= 3'd1;   // start a poll read
        else if (poll_cnt != 3'd0)
            poll_cnt <= poll_cnt + 3'd1;
    end

endmodule

`default_nettype wire

/* cfg_bus_driver.sv */
////////////////////////////////////////
// config bus driver
// sequencer bus cycles, saved refclk
// value, handover to the user port
////////////////////////////////////////
`default_nettype none

module cfg_bus_driver (
    input  wire                               clk,
    input  wire                               rstn,
    input  wire hpll_calib_pkg::calib_state_e state,
    input  wire  [3:0]                        det_cnt,
    input  wire  [1:0]                        wr_cnt,
    input  wire  [2:0]                        poll_cnt,
    input  wire                               calib_done,
    input  wire                               cfg_ready,
    input  wire  [hpll_calib_pkg::DATA_W-1:0] cfg_rdata,
    input  wire                               user_psel,
    input  wire                               user_penable,
    input  wire                               user_write,
    input  wire  [hpll_calib_pkg::ADDR_W-1:0] user_addr,
    input  wire  [hpll_calib_pkg::DATA_W-1:0] user_wdata,
    output logic                              cfg_psel,
    output logic                              cfg_penable,
    output logic                              cfg_write,
    output logic [hpll_calib_pkg::ADDR_W-1:0] cfg_addr,
    output logic [hpll_calib_pkg::DATA_W-1:0] cfg_wdata
);
    import hpll_calib_pkg::*;

    logic              seq_psel;
    logic              seq_penable;
    logic              seq_write;
    logic [ADDR_W-1:0] seq_addr;
    logic [DATA_W-1:0] seq_wdata;
    logic [DATA_W-1:0] refclk_saved;
    logic [DATA_W-1:0] refclk_mod;

    // keep the original refclk config for the restore write
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn)
            refclk_saved <= '0;
        else if (state == detect && det_cnt == DET_READ1_END && cfg_ready)
            refclk_saved <= cfg_rdata;
    end

    always_comb begin
        refclk_mod = refclk_saved;
        refclk_mod[CFG_FORCE_HI:CFG_FORCE_LO] = '1;
    end

    ////////////////////////////////////////
    // sequencer bus decode
    ////////////////////////////////////////
    always_comb begin
        seq_psel    = 1'b0;
        seq_penable = 1'b0;
        seq_addr    = '0;
        case (state)
            detect: begin
                seq_psel    = (det_cnt != DET_GAP);
                seq_penable = (det_cnt != 4'd0) && (det_cnt != DET_GAP) &&
                              (det_cnt != DET_GAP + 4'd1);   // setup of second read
                seq_addr    = (det_cnt < DET_GAP) ? ADDR_REFCLK_CFG : ADDR_CALIB_STATUS;
            end
            calib_start, calib_exit: begin
                seq_psel    = (wr_cnt != 2'd0);
                seq_penable = (wr_cnt > 2'd1);
                seq_addr    = ADDR_REFCLK_CFG;
            end
            calib_wait: begin
                seq_psel    = (poll_cnt != 3'd0);
                seq_penable = (poll_cnt > 3'd1);
                seq_addr    = ADDR_RESCAL_RESULT;
            end
            default: ;
        endcase
    end

    assign seq_write = (state == calib_start) || (state == calib_exit);
    assign seq_wdata = (state == calib_start) ? refclk_mod : refclk_saved;

    // user owns the bus once calibration is over
    assign cfg_psel    = calib_done ? user_psel    : seq_psel;
    assign cfg_penable = calib_done ? user_penable : seq_penable;
    assign cfg_write   = calib_done ? user_write   : seq_write;
    assign cfg_addr    = calib_done ? user_addr    : seq_addr;
    assign cfg_wdata   = calib_done ? user_wdata   : seq_wdata;

endmodule

`default_nettype wire

/* hpll_calib_top.sv */
////////////////////////////////////////
// PLL calibration sequencer top level
// FSM, phase counters, bus driver
////////////////////////////////////////
`default_nettype none

module hpll_calib_top #(
    parameter int WAIT_BITS   = 10,
    parameter int MAX_RDY_ERR = 2
) (
    input  wire                               clk,
    input  wire                               rstn,
    input  wire                               calib_en,
    input  wire                               user_psel,
    input  wire                               user_penable,
    input  wire                               user_write,
    input  wire  [hpll_calib_pkg::ADDR_W-1:0] user_addr,
    input  wire  [hpll_calib_pkg::DATA_W-1:0] user_wdata,
    input  wire                               cfg_ready,
    input  wire  [hpll_calib_pkg::DATA_W-1:0] cfg_rdata,
    output logic                              cfg_psel,
    output logic                              cfg_penable,
    output logic                              cfg_write,
    output logic [hpll_calib_pkg::ADDR_W-1:0] cfg_addr,
    output logic [hpll_calib_pkg::DATA_W-1:0] cfg_wdata,
    output logic                              calib_done,
    output logic                              res_cal_rst
);
    import hpll_calib_pkg::*;

    calib_state_e state;
    logic [3:0]   det_cnt;
    logic [1:0]   wr_cnt;
    logic [2:0]   poll_cnt;

    calib_fsm #(
        .MAX_RDY_ERR (MAX_RDY_ERR)
    ) calib_fsm_i (
        .clk         (clk),
        .rstn        (rstn),
        .calib_en    (calib_en),
        .det_cnt     (det_cnt),
        .wr_cnt      (wr_cnt),
        .poll_cnt    (poll_cnt),
        .cfg_ready   (cfg_ready),
        .cfg_rdata   (cfg_rdata),
        .state       (state),
        .calib_done  (calib_done),
        .res_cal_rst (res_cal_rst)
    );

    calib_step_counters #(
        .WAIT_BITS (WAIT_BITS)
    ) calib_step_counters_i (
        .clk      (clk),
        .rstn     (rstn),
        .state    (state),
        .det_cnt  (det_cnt),
        .wr_cnt   (wr_cnt),
        .poll_cnt (poll_cnt)
    );

    cfg_bus_driver cfg_bus_driver_i (
        .clk          (clk),
        .rstn         (rstn),
        .state        (state),
        .det_cnt      (det_cnt),
        .wr_cnt       (wr_cnt),
        .poll_cnt     (poll_cnt),
        .calib_done   (calib_done),
        .cfg_ready    (cfg_ready),
        .cfg_rdata    (cfg_rdata),
        .user_psel    (user_psel),
        .user_penable (user_penable),
        .user_write   (user_write),
        .user_addr    (user_addr),
        .user_wdata   (user_wdata),
        .cfg_psel     (cfg_psel),
        .cfg_penable  (cfg_penable),
        .cfg_write    (cfg_write),
        .cfg_addr     (cfg_addr),
        .cfg_wdata    (cfg_wdata)
    );

endmodule

`default_nettype wire

/* hpll_calib_sva.sv */
////////////////////////////////////////
// config bus protocol assertions
// bound into the config bus driver
////////////////////////////////////////
`default_nettype none

module hpll_calib_sva (
    input wire                              clk,
    input wire                              rstn,
    input wire                              calib_done,
    input wire                              cfg_psel,
    input wire                              cfg_penable,
    input wire                              cfg_write,
    input wire [hpll_calib_pkg::ADDR_W-1:0] cfg_addr
);

    penable_needs_psel: assert property (
        @(posedge clk) disable iff (!rstn) cfg_penable |-> cfg_psel
    ) else $error("penable high while psel low");

    // access phase only after a setup cycle
    setup_before_access: assert property (
        @(posedge clk) disable iff (!rstn)
        (!calib_done && $rose(cfg_penable)) |-> $past(cfg_psel)
    ) else $error("penable rose without a setup cycle");

    access_stable: assert property (
        @(posedge clk) disable iff (!rstn)
        (!calib_done && cfg_penable) |-> ($stable(cfg_addr) && $stable(cfg_write))
    ) else $error("address or direction changed inside an access");

    reset_values: assert property (
        @(posedge clk) !rstn |-> (!cfg_psel && !cfg_penable && !calib_done)
    ) else $error("bus outputs not idle in reset");

endmodule

bind cfg_bus_driver hpll_calib_sva hpll_calib_sva_i (
    .clk         (clk),
    .rstn        (rstn),
    .calib_done  (calib_done),
    .cfg_psel    (cfg_psel),
    .cfg_penable (cfg_penable),
    .cfg_write   (cfg_write),
    .cfg_addr    (cfg_addr)
);

`default_nettype wire

/* hpll_calib_tb.sv */
////////////////////////////////////////
// testbench for the calibration sequencer
// PLL register file model, stimulus table,
// bus observer and result checks
////////////////////////////////////////
`default_nettype none

module hpll_calib_tb;
    import hpll_calib_pkg::*;

    localparam int NUM_ROWS       = 6;
    localparam int TIMEOUT_CYCLES = NUM_ROWS * 400;
    localparam int QUIET_LIMIT    = 40;   // longer than any gap inside a run
    localparam logic [7:0] NO_DROP = 8'hff;

    typedef struct packed {
        logic [7:0] refclk;
        logic [7:0] status;
        logic [7:0] npolls;       // polls answered with done clear
        logic [7:0] drop0;        // access numbers answered without ready
        logic [7:0] drop1;
        logic       en;
        logic       exp_done;
        logic [7:0] exp_writes;
        logic [7:0] exp_detects;  // completed refclk reads
    } row_t;

    logic              clk;
    logic              rstn;
    logic              calib_en;
    logic              user_psel;
    logic              user_penable;
    logic              user_write;
    logic [ADDR_W-1:0] user_addr;
    logic [DATA_W-1:0] user_wdata;
    logic              cfg_ready = 1'b1;
    logic [DATA_W-1:0] cfg_rdata = '0;
    logic              cfg_psel;
    logic              cfg_penable;
    logic              cfg_write;
    logic [ADDR_W-1:0] cfg_addr;
    logic [DATA_W-1:0] cfg_wdata;
    logic              calib_done;
    logic              res_cal_rst;

    row_t   rows [NUM_ROWS];
    row_t   cur;
    int     errors;
    int     cycles;
    integer seed = 32'h07ce74a7;

    // register file model state
    int acc_idx;
    int poll_idx;

    // bus observer state
    int                cyc;
    int                first_psel;
    int                quiet;
    int                n_wr;
    int                n_ref_rd;
    int                n_poll_rd;
    int                n_pulse;
    int                pulse_wr;
    int                polls_at_restore;
    logic              early;
    logic              pend;
    logic              p_write;
    logic              p_ready;
    logic [ADDR_W-1:0] p_addr;
    logic [DATA_W-1:0] p_wdata;
    logic [ADDR_W-1:0] first_addr;
    logic              first_write;
    logic [ADDR_W-1:0] wr_addr [8];
    logic [DATA_W-1:0] wr_data [8];

    hpll_calib_top #(
        .WAIT_BITS   (3),
        .MAX_RDY_ERR (2)
    ) hpll_calib_top_i (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    ////////////////////////////////////////
    // PLL register file model
    ////////////////////////////////////////
    always @(posedge clk) begin
        #2;
        if (!rstn) begin
            acc_idx  = -1;
            poll_idx = -1;
        end else if (cfg_psel && !cfg_penable && !calib_done) begin
            acc_idx = acc_idx + 1;   // setup cycle opens an access
            if (cfg_addr == ADDR_RESCAL_RESULT)
                poll_idx = poll_idx + 1;
        end
        cfg_ready = !(acc_idx == int'(cur.drop0) || acc_idx == int'(cur.drop1));
        case (cfg_addr)
            ADDR_REFCLK_CFG:    cfg_rdata = cur.refclk;
            ADDR_CALIB_STATUS:  cfg_rdata = cur.status;
            ADDR_RESCAL_RESULT: cfg_rdata = (poll_idx >= int'(cur.npolls)) ? 8'h81 : 8'h80;
            default:            cfg_rdata = 8'h00;
        endcase
    end

    task automatic record_access();
        if (p_write) begin
            if (n_wr < 8) begin
                wr_addr[n_wr] = p_addr;
                wr_data[n_wr] = p_wdata;
            end
            if (n_wr == 1)
                polls_at_restore = n_poll_rd;
            n_wr++;
        end else if (p_addr == ADDR_REFCLK_CFG) begin
            n_ref_rd++;
        end else if (p_addr == ADDR_RESCAL_RESULT) begin
            n_poll_rd++;
        end
    endtask

    // completed accesses are the last penable cycle with ready high
    always @(negedge clk) begin
        if (!rstn) begin
            cyc              = 0;
            first_psel       = -1;
            quiet            = 0;
            n_wr             = 0;
            n_ref_rd         = 0;
            n_poll_rd        = 0;
            n_pulse          = 0;
            pulse_wr         = -1;
            polls_at_restore = -1;
            early            = 1'b0;
            pend             = 1'b0;
        end else begin
            if (cyc < 16 && (cfg_psel || calib_done || res_cal_rst))
                early = 1'b1;
            if (first_psel < 0 && cfg_psel) begin
                first_psel  = cyc;
                first_addr  = cfg_addr;
                first_write = cfg_write;
            end
            if (!calib_done) begin
                if (cfg_psel && cfg_penable) begin
                    pend    = 1'b1;
                    p_addr  = cfg_addr;
                    p_write = cfg_write;
                    p_wdata = cfg_wdata;
                    p_ready = cfg_ready;
                end else if (pend) begin
                    pend = 1'b0;
                    if (p_ready)
                        record_access();
                end
                if (res_cal_rst) begin
                    n_pulse++;
                    pulse_wr = n_wr;
                end
            end
            quiet = cfg_psel ? 0 : quiet + 1;
            cyc   = cyc + 1;
        end
    end

    ////////////////////////////////////////
    // reporting and row execution
    ////////////////////////////////////////
    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        errors++;
        $display("Fail t=%0t %s: got %0h expected %0h", $time, name, got, exp);
    endtask

    task automatic report_problem(input string msg);
        errors++;
        $display("Error at t=%0t: %s", $time, msg);
    endtask

    task automatic drive_user_traffic(input int n);
        logic [31:0] rnd;
        for (int i = 0; i < n; i++) begin
            @(posedge clk);
            #1;
            rnd          = $random(seed);
            user_psel    = rnd[0];
            user_penable = rnd[0] & rnd[1];
            user_write   = rnd[2];
            user_wdata   = rnd[15:8];
            user_addr    = rnd[27:16];
            #4;
            if (cfg_psel !== user_psel)
                report_mismatch("cfg_psel", 32'(cfg_psel), 32'(user_psel));
            if (cfg_penable !== user_penable)
                report_mismatch("cfg_penable", 32'(cfg_penable), 32'(user_penable));
            if (cfg_write !== user_write)
                report_mismatch("cfg_write", 32'(cfg_write), 32'(user_write));
            if (cfg_addr !== user_addr)
                report_mismatch("cfg_addr", 32'(cfg_addr), 32'(user_addr));
            if (cfg_wdata !== user_wdata)
                report_mismatch("cfg_wdata", 32'(cfg_wdata), 32'(user_wdata));
        end
    endtask

    task automatic run_row(input int r);
        int errs_before;
        errs_before = errors;
        @(posedge clk);
        #1;
        cur          = rows[r];
        rstn         = 1'b0;
        calib_en     = cur.en;
        user_psel    = 1'b0;
        user_penable = 1'b0;
        user_write   = 1'b0;
        user_addr    = '0;
        user_wdata   = '0;
        repeat (4) @(posedge clk);
        #1;
        rstn = 1'b1;
        do begin   // until done or the bus goes quiet
            @(posedge clk);
            #1;
        end while (!calib_done && quiet < QUIET_LIMIT);

        if (early)
            report_problem("bus or done activity during the settling time");
        if (first_psel != 16)
            report_mismatch("first psel cycle", 32'(first_psel), 32'd16);
        if (first_addr !== ADDR_REFCLK_CFG)
            report_mismatch("first cfg_addr", 32'(first_addr), 32'(ADDR_REFCLK_CFG));
        if (first_write !== 1'b0)
            report_mismatch("first cfg_write", 32'(first_write), 32'd0);
        if (calib_done !== cur.exp_done)
            report_mismatch("calib_done", 32'(calib_done), 32'(cur.exp_done));
        if (n_wr != int'(cur.exp_writes))
            report_mismatch("write count", 32'(n_wr), 32'(cur.exp_writes));
        if (n_ref_rd != int'(cur.exp_detects))
            report_mismatch("refclk read count", 32'(n_ref_rd), 32'(cur.exp_detects));
        if (cur.exp_writes == 8'd2) begin
            if (wr_addr[0] !== ADDR_REFCLK_CFG)
                report_mismatch("start write addr", 32'(wr_addr[0]), 32'(ADDR_REFCLK_CFG));
            if (wr_data[0] !== (cur.refclk | 8'h38))   // bits 5:3 forced
                report_mismatch("start write data", 32'(wr_data[0]), 32'(cur.refclk | 8'h38));
            if (wr_addr[1] !== ADDR_REFCLK_CFG)
                report_mismatch("restore write addr", 32'(wr_addr[1]), 32'(ADDR_REFCLK_CFG));
            if (wr_data[1] !== cur.refclk)
                report_mismatch("restore write data", 32'(wr_data[1]), 32'(cur.refclk));
            if (n_pulse != 1)
                report_mismatch("res_cal_rst pulses", 32'(n_pulse), 32'd1);
            if (pulse_wr != 1)
                report_problem("res_cal_rst pulse not between the two writes");
            if (polls_at_restore < int'(cur.npolls) + 1)
                report_problem("too few result polls before the restore write");
        end else if (n_pulse != 0) begin
            report_mismatch("res_cal_rst pulses", 32'(n_pulse), 32'd0);
        end
        if (calib_done)
            drive_user_traffic(4);

        if (errors == errs_before)
            $display("row %0d passed", r);
        else
            $display("row %0d failed with %0d errors", r, errors - errs_before);
    endtask

    initial begin
        rstn         = 1'b0;
        calib_en     = 1'b0;
        user_psel    = 1'b0;
        user_penable = 1'b0;
        user_write   = 1'b0;
        user_addr    = '0;
        user_wdata   = '0;
        errors       = 0;
        // refclk, status, polls, drop0, drop1, en, done, writes, detects
        rows[0] = '{8'h41, 8'h00, 8'd0, NO_DROP, NO_DROP, 1'b1, 1'b1, 8'd2, 8'd1};
        rows[1] = '{8'h86, 8'h0c, 8'd3, NO_DROP, NO_DROP, 1'b0, 1'b1, 8'd2, 8'd1};
        rows[2] = '{8'h5a, 8'h10, 8'd0, NO_DROP, NO_DROP, 1'b0, 1'b0, 8'd0, 8'd1};
        rows[3] = '{8'h5a, 8'h20, 8'd0, NO_DROP, NO_DROP, 1'b1, 1'b1, 8'd0, 8'd1};
        rows[4] = '{8'hc7, 8'h00, 8'd1, 8'd2,    NO_DROP, 1'b1, 1'b1, 8'd2, 8'd2};
        rows[5] = '{8'h13, 8'h00, 8'd0, 8'd2,    8'd5,    1'b1, 1'b1, 8'd0, 8'd2};
        for (int r = 0; r < NUM_ROWS; r++)
            run_row(r);
        $display("rows run %0d, errors %0d", NUM_ROWS, errors);
        if (errors == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

    // run limit
    initial begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: sequence did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Finished with errors");
        $finish;
    end

endmodule

`default_nettype wire

/* sources.f */
hpll_calib_pkg.sv
calib_fsm.sv
calib_step_counters.sv
cfg_bus_driver.sv
hpll_calib_top.sv
hpll_calib_sva.sv
hpll_calib_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = hpll_calib_tb
FILELIST  = sources.f
OBJ_DIR   = obj_dir
BIN       = $(OBJ_DIR)/V$(TOP)
PASS_MSG  = Finished with no errors
SOURCES   = $(filter %.sv %.v,$(shell cat $(FILELIST)))

.PHONY: all run clean

all: run

$(BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
